//--- flist.f
design/seq_pkg.sv
design/program_fetch.sv
design/seq_core.sv
design/device_port_bank.sv
design/seq_top.sv
sim/seq_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the sequencer testbench, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module seq_tb -o seq_sim \
   || { echo "compile failed"; exit 1; }
./obj_dir/seq_sim > sim.log 2>&1
cat sim.log
grep -q "STATUS: PASS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- sim/seq_tb.sv
`timescale 1ns/1ps

module seq_tb;

   typedef struct packed {
      logic [2:0]         dev;
      seq_pkg::dev_word_t word;
   } dev_event_t;

   logic                                          clock;
   logic                                          reset;
   logic                                          load_en;
   logic [7:0]                                    load_addr;
   seq_pkg::inst_t                                load_inst;
   logic                                          run;
   seq_pkg::ireg_bank_t                           iregs;
   seq_pkg::dev_word_t [seq_pkg::num_devices-1:0] dev_words;
   logic [seq_pkg::num_devices-1:0]               dev_strobe;
   logic [7:0]                                    next;
   logic                                          error;

   seq_pkg::inst_t prog [256];  // image of the program memory
   dev_event_t     exp_q [$];
   dev_event_t     obs_q [$];
   logic [31:0]    lfsr = 32'hae12;
   int             cycle = 0;
   int             deadline = 100;
   string          test_name = "init";

   seq_top #(.addr_width(8)) u_seq_top (.*);

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   always @(posedge clock) begin
      cycle++;
      if (cycle > deadline) begin
         $display("watchdog expired in %s at cycle %0d", test_name, cycle);
         stop_run();
      end
   end

   // every device strobe, with the word it delivers
   always @(negedge clock) begin
      if (!reset && dev_strobe != '0) begin
         assert ($onehot(dev_strobe)) else begin
            $display("ERROR %s strobe expected one-hot actual 0x%0h", test_name, dev_strobe);
            stop_run();
         end
         for (int d = 0; d < seq_pkg::num_devices; d++) begin
            if (dev_strobe[d]) obs_q.push_back('{dev: d[2:0], word: dev_words[d]});
         end
      end
   end

   task automatic stop_run();
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
      assert (expected === actual) else begin
         $display("ERROR %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
         stop_run();
      end
   endtask

   task automatic arm_watchdog(int steps);
      deadline = cycle + steps * 2 + 20;
   endtask

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] random_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic seq_pkg::inst_t make_inst(seq_pkg::opcode_e op, logic [2:0] dev,
                                                logic [3:0] cmd, logic [7:0] arg);
      seq_pkg::inst_t w;
      w = '0;
      w.op = op;
      w.body.dev.cmd = '{dev: dev, cmd: cmd, arg: arg};
      return w;
   endfunction

   function automatic seq_pkg::inst_t make_jump(seq_pkg::opcode_e op, logic [7:0] label,
                                                logic [1:0] src);
      seq_pkg::inst_t w;
      w = '0;
      w.op = op;
      w.body.jmp.label = label;
      w.body.jmp.src = src;
      return w;
   endfunction

   task automatic apply_reset();
      arm_watchdog(8);
      @(posedge clock);
      reset <= 1'b1;
      run <= 1'b0;
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      @(posedge clock);  // core leaves its reset state
   endtask

   task automatic load_program(int n);
      arm_watchdog(n);
      for (int a = 0; a < n; a++) begin
         @(posedge clock);
         load_en <= 1'b1;
         load_addr <= a[7:0];
         load_inst <= prog[a];
      end
      @(posedge clock);
      load_en <= 1'b0;
   endtask

   // reference execution from address 0 up to the closing self jump
   task automatic model_program(output int steps, output int final_pc);
      seq_pkg::inst_t w;
      dev_event_t     ev;
      logic [7:0]     src_val;
      int             pc;
      pc = 0;
      steps = 0;
      exp_q.delete();
      w = prog[0];
      while (!(w.op == seq_pkg::op_ji && w.body.jmp.label == pc[7:0]) && steps < 100) begin
         src_val = iregs[w.body.jmp.src];
         steps++;
         case (w.op)
            seq_pkg::op_ci, seq_pkg::op_cr: begin
               ev.dev = w.body.dev.cmd.dev;
               ev.word.cmd = w.body.dev.cmd.cmd;
               ev.word.arg = (w.op == seq_pkg::op_ci) ? w.body.dev.cmd.arg : src_val;
               exp_q.push_back(ev);
               pc = (pc + 1) % 256;
            end
            seq_pkg::op_ji: pc = int'(w.body.jmp.label);
            seq_pkg::op_jr: pc = int'(src_val);
            seq_pkg::op_jz: pc = (src_val == 0) ? int'(w.body.jmp.label) : (pc + 1) % 256;
            default:        pc = (pc + 1) % 256;  // no
         endcase
         w = prog[pc];
      end
      final_pc = pc;
   endtask

   task automatic run_program();
      int steps;
      int final_pc;
      model_program(steps, final_pc);
      arm_watchdog(steps);
      obs_q.delete();
      @(posedge clock);
      run <= 1'b1;
      do @(negedge clock); while (obs_q.size() < exp_q.size() || next != final_pc[7:0]);
      repeat (4) @(negedge clock);  // room for a stray strobe
      @(posedge clock);
      run <= 1'b0;
      check_value("event count", exp_q.size(), obs_q.size());
      foreach (exp_q[i]) check_value($sformatf("event %0d", i), 32'(exp_q[i]), 32'(obs_q[i]));
   endtask

   task automatic test_after_reset();
      test_name = "test_after_reset";
      apply_reset();
      @(negedge clock);
      check_value("dev_strobe", 0, 32'(dev_strobe));
      check_value("next", 0, 32'(next));
      check_value("error", 0, 32'(error));
      for (int d = 0; d < seq_pkg::num_devices; d++) begin
         check_value($sformatf("dev_words[%0d]", d), 0, 32'(dev_words[d]));
      end
   endtask

   task automatic test_ci_devices();
      seq_pkg::dev_word_t words [8];
      test_name = "test_ci_devices";
      for (int d = 0; d < 8; d++) begin
         words[d] = 12'(random_bits(12));
         prog[d] = make_inst(seq_pkg::op_ci, d[2:0], words[d].cmd, words[d].arg);
      end
      prog[8] = make_jump(seq_pkg::op_ji, 8'd8, 2'd0);
      apply_reset();
      load_program(9);
      run_program();
      @(negedge clock);
      for (int d = 0; d < 8; d++) begin
         check_value($sformatf("dev_words[%0d]", d), 32'(words[d]), 32'(dev_words[d]));
      end
   endtask

   task automatic test_cr_registers();
      test_name = "test_cr_registers";
      @(posedge clock);
      iregs <= random_bits(32);
      for (int s = 0; s < 4; s++) begin
         prog[s] = make_inst(seq_pkg::op_cr, 3'(s + 4), 4'(random_bits(4)),
                             {6'(random_bits(6)), s[1:0]});  // src in the low bits
      end
      prog[4] = make_jump(seq_pkg::op_ji, 8'd4, 2'd0);
      apply_reset();
      load_program(5);
      run_program();
      for (int s = 0; s < 4; s++) begin
         check_value($sformatf("arg of src %0d", s), 32'(iregs[s]), 32'(dev_words[s + 4].arg));
      end
   endtask

   task automatic test_jumps();
      test_name = "test_jumps";
      @(posedge clock);
      iregs <= {8'(random_bits(8)), 8'd10, 8'h5a, 8'h00};
      for (int a = 0; a < 22; a++) begin
         prog[a] = make_inst(seq_pkg::op_ci, 3'd7, 4'hf, 8'hee);  // marker, never reached
      end
      prog[0]  = make_jump(seq_pkg::op_ji, 8'd2, 2'd0);
      prog[2]  = make_inst(seq_pkg::op_ci, 3'd0, 4'h1, 8'(random_bits(8)));
      prog[3]  = make_jump(seq_pkg::op_jr, 8'd0, 2'd2);   // ireg 2 holds 10
      prog[10] = make_jump(seq_pkg::op_jz, 8'd4, 2'd1);   // ireg 1 nonzero, falls through
      prog[11] = make_inst(seq_pkg::op_ci, 3'd1, 4'h2, 8'(random_bits(8)));
      prog[12] = make_jump(seq_pkg::op_jz, 8'd20, 2'd0);  // taken
      prog[20] = make_inst(seq_pkg::op_ci, 3'd2, 4'h3, 8'(random_bits(8)));
      prog[21] = make_jump(seq_pkg::op_ji, 8'd21, 2'd0);
      apply_reset();
      load_program(22);
      run_program();
      check_value("device events", 3, obs_q.size());
   endtask

   task automatic test_no_timing();
      int issue_cycle [$];
      int strobe_cycle;
      int run_cycle;
      test_name = "test_no_timing";
      for (int a = 0; a < 5; a++) prog[a] = make_inst(seq_pkg::op_no, 3'd0, 4'h0, 8'h00);
      prog[5] = make_inst(seq_pkg::op_ci, 3'd3, 4'h9, 8'(random_bits(8)));
      prog[6] = make_jump(seq_pkg::op_ji, 8'd6, 2'd0);
      apply_reset();
      load_program(7);
      arm_watchdog(8);
      strobe_cycle = 0;
      @(posedge clock);
      run <= 1'b1;
      @(negedge clock);
      run_cycle = cycle;
      while (issue_cycle.size() < 7 || strobe_cycle == 0) begin
         @(negedge clock);
         if (u_seq_top.inst_en) begin
            check_value($sformatf("next at issue %0d", issue_cycle.size()),
                        issue_cycle.size(), 32'(next));
            issue_cycle.push_back(cycle);
         end
         if (dev_strobe != '0) strobe_cycle = cycle;
      end
      check_value("first issue delay", 2, issue_cycle[0] - run_cycle);
      for (int i = 1; i < 7; i++) begin
         check_value("issue spacing", 2, issue_cycle[i] - issue_cycle[i - 1]);
      end
      check_value("ci strobe delay", 2, strobe_cycle - issue_cycle[5]);
      @(posedge clock);
      run <= 1'b0;
   endtask

   task automatic test_error();
      test_name = "test_error";
      prog[0] = make_inst(seq_pkg::op_ci, 3'd4, 4'h7, 8'(random_bits(8)));
      prog[1] = make_inst(seq_pkg::op_no, 3'd0, 4'h0, 8'h00);
      prog[2] = make_inst(seq_pkg::opcode_e'(4'hf), 3'd0, 4'h0, 8'h00);
      prog[3] = make_inst(seq_pkg::op_ci, 3'd5, 4'h7, 8'h11);
      apply_reset();
      load_program(4);
      arm_watchdog(8);
      obs_q.delete();
      @(posedge clock);
      run <= 1'b1;
      do @(negedge clock); while (!error);
      check_value("next in error", 0, 32'(next));
      repeat (10) @(negedge clock);  // run still high
      check_value("error held", 1, 32'(error));
      check_value("strobe count", 1, obs_q.size());
      check_value("strobed device", 4, 32'(obs_q[0].dev));
      apply_reset();
      @(negedge clock);
      check_value("error after reset", 0, 32'(error));
      check_value("next after reset", 0, 32'(next));
   endtask

   initial begin
      reset = 1'b1;
      load_en = 1'b0;
      load_addr = '0;
      load_inst = '0;
      run = 1'b0;
      iregs = '0;
      test_after_reset();
      test_ci_devices();
      test_cr_registers();
      test_jumps();
      test_no_timing();
      test_error();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- design/seq_top.sv
`timescale 1ns/1ps

module seq_top #(
   parameter int addr_width = 8
) (
   input  logic                                                clock,
   input  logic                                                reset,

   input  logic                                                load_en,
   input  logic [addr_width-1:0]                               load_addr,
   input  seq_pkg::inst_t                                      load_inst,

   input  logic                                                run,
   input  seq_pkg::ireg_bank_t                                 iregs,

   output seq_pkg::dev_word_t [seq_pkg::num_devices-1:0]       dev_words,
   output logic [seq_pkg::num_devices-1:0]                     dev_strobe,
   output logic [addr_width-1:0]                               next,
   output logic                                                error
);

   seq_pkg::inst_t                    inst;
   logic                              inst_en;
   seq_pkg::dev_word_t                oreg;
   logic [seq_pkg::num_devices-1:0]   oreg_wen;

   program_fetch #(.addr_width(addr_width)) u_fetch (
      .clock     (clock),
      .reset     (reset),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_inst (load_inst),
      .run       (run),
      .halt      (error),  // stop fetching once the core faults
      .next      (next),
      .inst      (inst),
      .inst_en   (inst_en)
   );

   seq_core #(.addr_width(addr_width)) u_core (
      .clock    (clock),
      .reset    (reset),
      .inst     (inst),
      .inst_en  (inst_en),
      .iregs    (iregs),
      .next     (next),
      .oreg     (oreg),
      .oreg_wen (oreg_wen),
      .error    (error)
   );

   device_port_bank u_ports (
      .clock      (clock),
      .reset      (reset),
      .oreg       (oreg),
      .oreg_wen   (oreg_wen),
      .dev_words  (dev_words),
      .dev_strobe (dev_strobe)
   );

endmodule

//--- design/device_port_bank.sv
`timescale 1ns/1ps

module device_port_bank (
   input  logic                                                clock,
   input  logic                                                reset,

   input  seq_pkg::dev_word_t                                  oreg,
   input  logic [seq_pkg::num_devices-1:0]                     oreg_wen,

   output seq_pkg::dev_word_t [seq_pkg::num_devices-1:0]       dev_words,
   output logic [seq_pkg::num_devices-1:0]                     dev_strobe
);

   // one command register per device
   always_ff @(posedge clock) begin
      if (reset) begin
         dev_words <= '0;
      end else begin
         for (int i = 0; i < seq_pkg::num_devices; i++) begin
            if (oreg_wen[i]) begin
               dev_words[i] <= oreg;  // otherwise keep last command
            end
         end
      end
   end

   // strobe lines up with the new word
   always_ff @(posedge clock) begin
      if (reset) begin
         dev_strobe <= '0;
      end else begin
         dev_strobe <= oreg_wen;
      end
   end

   // a single device is addressed per command
   assert property (@(posedge clock) disable iff (reset) $onehot0(dev_strobe))
      else $error("more than one device strobe");

endmodule

//--- design/seq_core.sv
`timescale 1ns/1ps

module seq_core #(
   parameter int addr_width = 8
) (
   input  logic                                clock,
   input  logic                                reset,

   input  seq_pkg::inst_t                      inst,
   input  logic                                inst_en,
   input  seq_pkg::ireg_bank_t                 iregs,

   output logic [addr_width-1:0]               next,
   output seq_pkg::dev_word_t                  oreg,
   output logic [seq_pkg::num_devices-1:0]     oreg_wen,
   output logic                                error
);

   typedef enum logic [1:0] {
      st_reset = 2'h0,
      st_ready = 2'h1,
      st_error = 2'h2
   } state_e;

   state_e state;

   seq_pkg::dev_cmd_t                 dc;
   seq_pkg::jump_t                    jmp;
   logic [seq_pkg::word_width-1:0]    ireg_sel;
   logic [seq_pkg::num_devices-1:0]   dev_onehot;
   logic [addr_width-1:0]             next_inc;
   logic [addr_width-1:0]             label_addr;
   logic [addr_width-1:0]             ireg_addr;
   logic                              exec;

   // both views of the body word
   assign dc  = inst.body.dev.cmd;
   assign jmp = inst.body.jmp;

   assign ireg_sel   = iregs[jmp.src];  // src sits in bits 1:0 in either view
   assign dev_onehot = {{(seq_pkg::num_devices - 1){1'b0}}, 1'b1} << dc.dev;

   assign next_inc   = next + 1'b1;             // wraps at 2^addr_width
   assign label_addr = addr_width'(jmp.label);  // truncate or zero extend
   assign ireg_addr  = addr_width'(ireg_sel);

   assign exec  = (state == st_ready) && inst_en;
   assign error = (state == st_error);

   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= st_reset;
         next     <= '0;
         oreg_wen <= '0;
      end else begin
         oreg_wen <= '0;  // strobe only for ci / cr
         case (state)
            st_reset: begin
               state <= st_ready;  // one idle cycle, inst_en ignored
               next  <= '0;
            end

            st_ready: begin
               if (inst_en) begin
                  case (inst.op)
                     seq_pkg::op_no: next <= next_inc;

                     seq_pkg::op_ci,
                     seq_pkg::op_cr: begin
                        next     <= next_inc;
                        oreg_wen <= dev_onehot;
                     end

                     seq_pkg::op_ji: next <= label_addr;

                     seq_pkg::op_jr: next <= ireg_addr;

                     seq_pkg::op_jz: begin
                        next <= (ireg_sel == '0) ? label_addr : next_inc;
                     end

                     default: begin
                        // unknown opcode, sticky until reset
                        state <= st_error;
                        next  <= '0;
                     end
                  endcase
               end
            end

            st_error: next <= '0;

            default: begin
               state <= st_error;
               next  <= '0;
            end
         endcase
      end
   end

   // command word, only meaningful with oreg_wen
   always_ff @(posedge clock) begin
      if (exec) begin
         case (inst.op)
            seq_pkg::op_ci: oreg <= '{cmd: dc.cmd, arg: dc.arg};
            seq_pkg::op_cr: oreg <= '{cmd: dc.cmd, arg: ireg_sel};
            default:        oreg <= oreg;
         endcase
      end
   end

   // one device at most
   assert property (@(posedge clock) disable iff (reset) $onehot0(oreg_wen))
      else $error("oreg_wen not zero or one-hot");

endmodule

//--- design/program_fetch.sv
`timescale 1ns/1ps

module program_fetch #(
   parameter int addr_width = 8
) (
   input  logic                  clock,
   input  logic                  reset,

   input  logic                  load_en,
   input  logic [addr_width-1:0] load_addr,
   input  seq_pkg::inst_t        load_inst,

   input  logic                  run,
   input  logic                  halt,   // core in error
   input  logic [addr_width-1:0] next,

   output seq_pkg::inst_t        inst,
   output logic                  inst_en
);

   localparam int depth = 1 << addr_width;

   seq_pkg::inst_t mem [depth];

   logic phase;  // 0 = arm, 1 = issue
   logic go;

   assign go = run && !halt;

   // program load port, word readable from the next cycle
   always_ff @(posedge clock) begin
      if (load_en) begin
         mem[load_addr] <= load_inst;
      end
   end

   // read at next on the issue edge
   // the core moved next on the arm edge before, so the address is current
   always_ff @(posedge clock) begin
      if (phase && go) begin
         inst <= mem[next];
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         phase   <= 1'b0;
         inst_en <= 1'b0;
      end else begin
         inst_en <= phase && go;   // one cycle strobe
         phase   <= go && !phase;  // arm, issue, arm ...
      end
   end

   // only one instruction in flight
   assert property (@(posedge clock) disable iff (reset) inst_en |=> !inst_en)
      else $error("inst_en high in two consecutive cycles");

endmodule

//--- design/seq_pkg.sv
package seq_pkg;

   localparam int num_devices = 8;
   localparam int num_iregs   = 4;
   localparam int word_width  = 8;

   typedef enum logic [3:0] {
      op_no = 4'h0,  // advance only
      op_ci = 4'h1,  // command, immediate arg
      op_cr = 4'h2,  // command, arg from ireg
      op_ji = 4'h3,  // jump to label
      op_jr = 4'h4,  // jump to ireg value
      op_jz = 4'h5   // jump to label if ireg is zero
   } opcode_e;

   // command view of the low 15 bits
   typedef struct packed {
      logic [2:0]            dev;
      logic [3:0]            cmd;
      logic [word_width-1:0] arg;  // arg[1:0] doubles as src for cr
   } dev_cmd_t;

   typedef struct packed {
      logic     pad;  // bit 15, unused
      dev_cmd_t cmd;
   } dev_body_t;

   // jump view of the same 16 bits
   typedef struct packed {
      logic [7:0] label;
      logic [5:0] pad;
      logic [1:0] src;  // same place as in the command view
   } jump_t;

   // one body word, decoded either as a device command or as a jump
   typedef union packed {
      dev_body_t dev;
      jump_t     jmp;
   } inst_body_u;

   typedef struct packed {
      opcode_e    op;
      inst_body_u body;
   } inst_t;  // 20 bits

   // what a device port finally receives
   typedef struct packed {
      logic [3:0]            cmd;
      logic [word_width-1:0] arg;
   } dev_word_t;  // 12 bits

   typedef logic [num_iregs-1:0][word_width-1:0] ireg_bank_t;

endpackage
